// ==== source/skinny_cipher_pkg.sv ====
// SKINNY-128-384 cipher package with block types, S-box and round constants
package skinny_cipher_pkg;

    localparam int block_cells = 16;    // 4x4 cells of one byte
    localparam int load_beats  = 16;    // Beats per encryption job

    // Cell 0 sits in the most significant byte
    typedef logic [0:block_cells-1][7:0] block_t;

    // TK1, TK2, TK3 with TK1 most significant
    typedef block_t [0:2] tweakey_t;

    //////////////////////
    // SubCells table
    //////////////////////

    localparam logic [7:0] sbox [256] = '{
        8'h65, 8'h4c, 8'h6a, 8'h42, 8'h4b, 8'h63, 8'h43, 8'h6b,
        8'h55, 8'h75, 8'h5a, 8'h7a, 8'h53, 8'h73, 8'h5b, 8'h7b,
        8'h35, 8'h8c, 8'h3a, 8'h81, 8'h89, 8'h33, 8'h80, 8'h3b,
        8'h95, 8'h25, 8'h98, 8'h2a, 8'h90, 8'h23, 8'h99, 8'h2b,
        8'he5, 8'hcc, 8'he8, 8'hc1, 8'hc9, 8'he0, 8'hc0, 8'he9,
        8'hd5, 8'hf5, 8'hd8, 8'hf8, 8'hd0, 8'hf0, 8'hd9, 8'hf9,
        8'ha5, 8'h1c, 8'ha8, 8'h12, 8'h1b, 8'ha0, 8'h13, 8'ha9,
        8'h05, 8'hb5, 8'h0a, 8'hb8, 8'h03, 8'hb0, 8'h0b, 8'hb9,
        8'h32, 8'h88, 8'h3c, 8'h85, 8'h8d, 8'h34, 8'h84, 8'h3d,
        8'h91, 8'h22, 8'h9c, 8'h2c, 8'h94, 8'h24, 8'h9d, 8'h2d,
        8'h62, 8'h4a, 8'h6c, 8'h45, 8'h4d, 8'h64, 8'h44, 8'h6d,
        8'h52, 8'h72, 8'h5c, 8'h7c, 8'h54, 8'h74, 8'h5d, 8'h7d,
        8'ha1, 8'h1a, 8'hac, 8'h15, 8'h1d, 8'ha4, 8'h14, 8'had,
        8'h02, 8'hb1, 8'h0c, 8'hbc, 8'h04, 8'hb4, 8'h0d, 8'hbd,
        8'he1, 8'hc8, 8'hec, 8'hc5, 8'hcd, 8'he4, 8'hc4, 8'hed,
        8'hd1, 8'hf1, 8'hdc, 8'hfc, 8'hd4, 8'hf4, 8'hdd, 8'hfd,
        8'h36, 8'h8e, 8'h38, 8'h82, 8'h8b, 8'h30, 8'h83, 8'h39,
        8'h96, 8'h26, 8'h9a, 8'h28, 8'h93, 8'h20, 8'h9b, 8'h29,
        8'h66, 8'h4e, 8'h68, 8'h41, 8'h49, 8'h60, 8'h40, 8'h69,
        8'h56, 8'h76, 8'h58, 8'h78, 8'h50, 8'h70, 8'h59, 8'h79,
        8'ha6, 8'h1e, 8'haa, 8'h11, 8'h19, 8'ha3, 8'h10, 8'hab,
        8'h06, 8'hb6, 8'h08, 8'hba, 8'h00, 8'hb3, 8'h09, 8'hbb,
        8'he6, 8'hce, 8'hea, 8'hc2, 8'hcb, 8'he3, 8'hc3, 8'heb,
        8'hd6, 8'hf6, 8'hda, 8'hfa, 8'hd3, 8'hf3, 8'hdb, 8'hfb,
        8'h31, 8'h8a, 8'h3e, 8'h86, 8'h8f, 8'h37, 8'h87, 8'h3f,
        8'h92, 8'h21, 8'h9e, 8'h2e, 8'h97, 8'h27, 8'h9f, 8'h2f,
        8'h61, 8'h48, 8'h6e, 8'h46, 8'h4f, 8'h67, 8'h47, 8'h6f,
        8'h51, 8'h71, 8'h5e, 8'h7e, 8'h57, 8'h77, 8'h5f, 8'h7f,
        8'ha2, 8'h18, 8'hae, 8'h16, 8'h1f, 8'ha7, 8'h17, 8'haf,
        8'h01, 8'hb2, 8'h0e, 8'hbe, 8'h07, 8'hb7, 8'h0f, 8'hbf,
        8'he2, 8'hca, 8'hee, 8'hc6, 8'hcf, 8'he7, 8'hc7, 8'hef,
        8'hd2, 8'hf2, 8'hde, 8'hfe, 8'hd7, 8'hf7, 8'hdf, 8'hff
    };

    //////////////////////
    // Round constants
    //////////////////////

    // 6-bit LFSR stepped once per round, starting from zero
    // Evaluated at elaboration, so round 0 gives 6'h01
    function automatic logic [5:0] round_constant(input int index);
        logic [5:0] rc;
        rc = '0;
        for (int r = 0; r <= index; r++) begin
            rc = {rc[4:0], rc[5] ^ rc[4] ^ 1'b1};
        end
        return rc;
    endfunction

endpackage

// ==== source/skinny_link_pkg.sv ====
// SKINNY link package with the beat and job records passed between stages
package skinny_link_pkg;

    // One input beat, most significant beat of a job first
    typedef struct packed {
        logic [7:0]  text_byte;       // Plaintext byte
        logic [23:0] tweakey_slice;   // 24 bits of the 384-bit tweakey
    } load_beat_t;

    // One job travelling down the round pipeline
    typedef struct packed {
        logic                        valid;     // Low marks a bubble
        skinny_cipher_pkg::block_t   state;     // Cipher state
        skinny_cipher_pkg::tweakey_t tweakey;   // Round tweakey words
    } job_t;

endpackage

// ==== source/skinny_loader.sv ====
// SKINNY job loader, gathers sixteen text and tweakey beats into one job
`timescale 1ns/1ps

module skinny_loader (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        in_valid,
    input  skinny_link_pkg::load_beat_t in_beat,
    output logic                        in_ready,
    input  logic                        advance,
    output skinny_link_pkg::job_t       job
);

    localparam int beats      = skinny_cipher_pkg::load_beats;
    localparam int cells      = skinny_cipher_pkg::block_cells;
    localparam int tk_bits    = $bits(skinny_cipher_pkg::tweakey_t);
    localparam int slice_bits = tk_bits / beats;   // 24 bits per beat
    localparam int count_bits = $clog2(beats);

    localparam logic [count_bits-1:0] last_count = count_bits'(beats - 1);

    logic [count_bits-1:0]     beat_count;
    logic                      job_valid;
    skinny_cipher_pkg::block_t text_q;
    logic [tk_bits-1:0]        tweakey_q;
    logic                      accept;
    logic                      last_beat;

    // Room for a beat unless a finished job is stuck in front of a stall
    assign in_ready  = !job_valid || advance;
    assign accept    = in_valid && in_ready;
    assign last_beat = (beat_count == last_count);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            beat_count <= '0;
            job_valid  <= 1'b0;
        end else begin
            if (accept) begin
                beat_count <= last_beat ? '0 : beat_count + 1'b1;
            end
            if (accept && last_beat) begin
                job_valid <= 1'b1;               // Complete job ready for stage 0
            end else if (advance) begin
                job_valid <= 1'b0;               // Taken by stage 0
            end
        end
    end

    // Shift in from the low end, so the first beat ends up on top
    always_ff @(posedge clock) begin
        if (accept) begin
            text_q    <= {text_q[1:cells-1], in_beat.text_byte};
            tweakey_q <= {tweakey_q[tk_bits-slice_bits-1:0], in_beat.tweakey_slice};
        end
    end

    assign job = '{valid: job_valid, state: text_q, tweakey: tweakey_q};

endmodule

// ==== source/skinny_round.sv ====
// SKINNY round stage, one registered cipher round and its tweakey update
`timescale 1ns/1ps

module skinny_round #(
    parameter int round_index = 0
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  advance,
    input  skinny_link_pkg::job_t job_in,
    output skinny_link_pkg::job_t job_out
);

    localparam int cells = skinny_cipher_pkg::block_cells;

    localparam logic [5:0] round_const = skinny_cipher_pkg::round_constant(round_index);

    // Tweakey cell permutation PT
    localparam int tk_perm [cells] = '{9, 15, 8, 13, 10, 14, 12, 11, 0, 1, 2, 3, 4, 5, 6, 7};

    skinny_cipher_pkg::block_t   sub_state;
    skinny_cipher_pkg::block_t   const_state;
    skinny_cipher_pkg::block_t   key_state;
    skinny_cipher_pkg::block_t   shift_state;
    skinny_cipher_pkg::block_t   mix_state;
    skinny_cipher_pkg::tweakey_t tk_next;
    skinny_cipher_pkg::block_t   state_q;
    skinny_cipher_pkg::tweakey_t tweakey_q;
    logic                        valid_q;

    //////////////////////
    // State path
    //////////////////////

    always_comb begin
        for (int c = 0; c < cells; c++) begin
            sub_state[c] = skinny_cipher_pkg::sbox[job_in.state[c]];
        end

        // Constant lands in column 0 of rows 0..2
        const_state    = sub_state;
        const_state[0] = sub_state[0] ^ {4'h0, round_const[3:0]};
        const_state[4] = sub_state[4] ^ {6'h0, round_const[5:4]};
        const_state[8] = sub_state[8] ^ 8'h02;

        key_state = const_state;
        for (int c = 0; c < 8; c++) begin                // Rows 0 and 1 only
            key_state[c] = const_state[c] ^ job_in.tweakey[0][c]
                           ^ job_in.tweakey[1][c] ^ job_in.tweakey[2][c];
        end

        // Row r rotates right by r cells
        for (int r = 0; r < 4; r++) begin
            for (int j = 0; j < 4; j++) begin
                shift_state[4*r + j] = key_state[4*r + (j + 4 - r) % 4];
            end
        end

        for (int j = 0; j < 4; j++) begin
            mix_state[j]      = shift_state[j] ^ shift_state[8+j] ^ shift_state[12+j];
            mix_state[4 + j]  = shift_state[j];
            mix_state[8 + j]  = shift_state[4+j] ^ shift_state[8+j];
            mix_state[12 + j] = shift_state[j] ^ shift_state[8+j];
        end
    end

    //////////////////////
    // Tweakey schedule
    //////////////////////

    always_comb begin
        for (int w = 0; w < 3; w++) begin
            for (int c = 0; c < cells; c++) begin
                tk_next[w][c] = job_in.tweakey[w][tk_perm[c]];
            end
        end
        // LFSRs only touch the top two rows after the permutation
        for (int c = 0; c < 8; c++) begin
            tk_next[1][c] = {tk_next[1][c][6:0], tk_next[1][c][7] ^ tk_next[1][c][5]};
            tk_next[2][c] = {tk_next[2][c][0] ^ tk_next[2][c][6], tk_next[2][c][7:1]};
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= job_in.valid;        // Bubbles move along too
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            state_q   <= mix_state;
            tweakey_q <= tk_next;
        end
    end

    assign job_out = '{valid: valid_q, state: state_q, tweakey: tweakey_q};

endmodule

// ==== source/skinny_drain.sv ====
// SKINNY output drain, holds a finished ciphertext for the consumer
`timescale 1ns/1ps

module skinny_drain (
    input  logic                      clock,
    input  logic                      reset,
    input  skinny_link_pkg::job_t     job_in,
    output logic                      advance,
    output logic                      out_valid,
    input  logic                      out_ready,
    output skinny_cipher_pkg::block_t out_data
);

    logic                      full;
    skinny_cipher_pkg::block_t data_q;

    // Whole pipeline moves when the output slot frees up this cycle
    assign advance = !full || out_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            full <= 1'b0;
        end else if (advance) begin
            full <= job_in.valid;
        end
    end

    // Tweakey of the last stage is not kept
    always_ff @(posedge clock) begin
        if (advance && job_in.valid) begin
            data_q <= job_in.state;
        end
    end

    assign out_valid = full;
    assign out_data  = data_q;

endmodule

// ==== source/skinny_top.sv ====
// SKINNY-128-384 pipelined encryptor top, loader then round stages then drain
`timescale 1ns/1ps

module skinny_top #(
    parameter int rounds = 56
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        in_valid,
    input  skinny_link_pkg::load_beat_t in_beat,
    output logic                        in_ready,
    output logic                        out_valid,
    input  logic                        out_ready,
    output skinny_cipher_pkg::block_t   out_data
);

    // Entry i feeds round stage i, last entry feeds the drain
    skinny_link_pkg::job_t stage_job [0:rounds];
    logic                  advance;

    skinny_loader loader_i (
        .clock    (clock),
        .reset    (reset),
        .in_valid (in_valid),
        .in_beat  (in_beat),
        .in_ready (in_ready),
        .advance  (advance),
        .job      (stage_job[0])
    );

    for (genvar i = 0; i < rounds; i++) begin : g_round
        skinny_round #(
            .round_index (i)
        ) round_i (
            .clock   (clock),
            .reset   (reset),
            .advance (advance),
            .job_in  (stage_job[i]),
            .job_out (stage_job[i+1])
        );
    end

    skinny_drain drain_i (
        .clock     (clock),
        .reset     (reset),
        .job_in    (stage_job[rounds]),
        .advance   (advance),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

// ==== bench/skinny_assert.sv ====
// SKINNY output handshake assertions, bound into the encryptor top level
`timescale 1ns/1ps

module skinny_assert (
    input logic                      clock,
    input logic                      reset,
    input logic                      in_ready,
    input logic                      out_valid,
    input logic                      out_ready,
    input skinny_cipher_pkg::block_t out_data
);

    int failure_count = 0;     // Read by the testbench at the end

    // Stalled output must hold valid and data
    hold_when_stalled: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            failure_count++;
            $error("out_valid or out_data changed while out_ready was low");
        end

    quiet_in_reset: assert property (@(posedge clock) reset |-> !out_valid)
        else begin
            failure_count++;
            $error("out_valid high during reset");
        end

    ready_known: assert property (@(posedge clock) disable iff (reset) !$isunknown(in_ready))
        else begin
            failure_count++;
            $error("in_ready unknown after reset");
        end

endmodule

// ==== include/skinny_ref.svh ====
// SKINNY-128-384 reference model, one function over whole blocks
`ifndef skinny_ref_svh
`define skinny_ref_svh

function automatic skinny_cipher_pkg::block_t skinny_encrypt(
    input skinny_cipher_pkg::block_t   plain,
    input skinny_cipher_pkg::tweakey_t tweakey,
    input int                          num_rounds
);
    skinny_cipher_pkg::block_t   s;
    skinny_cipher_pkg::block_t   t;
    skinny_cipher_pkg::tweakey_t tk;
    logic [5:0]                  rc;
    int                          pt [16] = '{9, 15, 8, 13, 10, 14, 12, 11,
                                             0, 1, 2, 3, 4, 5, 6, 7};
    s  = plain;
    tk = tweakey;
    rc = '0;
    for (int r = 0; r < num_rounds; r++) begin
        rc = {rc[4:0], rc[5] ^ rc[4] ^ 1'b1};
        for (int i = 0; i < 16; i++)
            s[i] = skinny_cipher_pkg::sbox[s[i]];
        s[0] ^= {4'h0, rc[3:0]};
        s[4] ^= {6'h0, rc[5:4]};
        s[8] ^= 8'h02;
        for (int i = 0; i < 8; i++)
            s[i] ^= tk[0][i] ^ tk[1][i] ^ tk[2][i];
        t = s;
        for (int i = 0; i < 16; i++)
            s[i] = t[4 * (i / 4) + (i % 4 + 4 - i / 4) % 4];   // ShiftRows
        t = s;
        for (int j = 0; j < 4; j++) begin
            s[j]      = t[j] ^ t[8+j] ^ t[12+j];
            s[4 + j]  = t[j];
            s[8 + j]  = t[4+j] ^ t[8+j];
            s[12 + j] = t[j] ^ t[8+j];
        end
        for (int k = 0; k < 3; k++) begin
            t = tk[k];
            for (int i = 0; i < 16; i++)
                tk[k][i] = t[pt[i]];
        end
        for (int i = 0; i < 8; i++) begin
            tk[1][i] = {tk[1][i][6:0], tk[1][i][7] ^ tk[1][i][5]};
            tk[2][i] = {tk[2][i][0] ^ tk[2][i][6], tk[2][i][7:1]};
        end
    end
    return s;
endfunction

`endif

// ==== bench/skinny_tb.sv ====
// SKINNY-128-384 encryptor testbench with random jobs, stalls and a reference model
`timescale 1ns/1ps

module skinny_tb;

    localparam int rounds         = 56;
    localparam int load_beats     = skinny_cipher_pkg::load_beats;
    localparam int beat_timeout   = 1000;      // Cycles per beat
    localparam int drain_timeout  = 20000;     // Cycles for outstanding results
    localparam logic [31:0] seed  = 32'h6085611d;

    logic                        clock = 1'b0;
    logic                        reset;
    logic                        in_valid;
    skinny_link_pkg::load_beat_t in_beat;
    logic                        in_ready;
    logic                        out_valid;
    logic                        out_ready;
    skinny_cipher_pkg::block_t   out_data;

    skinny_cipher_pkg::block_t expected_q [$];
    logic [31:0] stim_rng  = seed;
    logic [31:0] stall_rng = {seed[15:0], seed[31:16]};
    bit gaps_on  = 1'b0;
    bit stall_on = 1'b0;
    int jobs_accepted = 0;
    int results       = 0;
    int max_in_flight = 0;
    int mismatches    = 0;
    int failures      = 0;
    int timeouts      = 0;

    `include "skinny_ref.svh"

    skinny_top #(.rounds(rounds)) dut_i (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    bind skinny_top skinny_assert assert_i (
        .clock     (clock),
        .reset     (reset),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #50 clock = ~clock;     // 100 ns period

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_rng = xorshift(stim_rng);
        return stim_rng;
    endfunction

    function automatic skinny_cipher_pkg::block_t random_block();
        return {next_stim(), next_stim(), next_stim(), next_stim()};
    endfunction

    task automatic check_equal(input string what, input logic [127:0] got,
                               input logic [127:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            mismatches++;
        end
    endtask

    // Sends one job beat by beat with cell 0 and the top tweakey slice first
    task automatic send_job(input skinny_cipher_pkg::block_t plain,
                            input skinny_cipher_pkg::tweakey_t tk);
        logic [383:0] tk_flat;
        int           gap;
        int           waited;
        bit           taken;
        tk_flat = tk;
        expected_q.push_back(skinny_encrypt(plain, tk, rounds));
        for (int b = 0; b < load_beats; b++) begin
            gap = 0;
            if (gaps_on && (next_stim() % 4) == 0) begin
                gap = 1 + next_stim() % 3;
            end
            repeat (gap) begin
                @(negedge clock);
                in_valid = 1'b0;
            end
            @(negedge clock);
            in_valid                = 1'b1;
            in_beat.text_byte       = plain[b];
            in_beat.tweakey_slice   = tk_flat[383 - 24*b -: 24];
            taken  = 1'b0;
            waited = 0;
            while (!taken && waited < beat_timeout) begin
                @(posedge clock);
                taken = in_ready;          // Value before this edge
                waited++;
            end
            if (!taken) begin
                $display("Timeout: in_ready stayed low for %0d cycles during a job", waited);
                timeouts++;
                return;
            end
        end
        jobs_accepted++;
    endtask

    task automatic release_input();
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic wait_for_results(input string phase);
        int waited;
        waited = 0;
        while (results < jobs_accepted && waited < drain_timeout) begin
            @(negedge clock);
            waited++;
        end
        if (results < jobs_accepted) begin
            $display("Timeout: only %0d of %0d results arrived in the %s phase",
                     results, jobs_accepted, phase);
            timeouts++;
        end
    endtask

    ////////////////////
    // Monitors
    ////////////////////

    // Compare every output transfer with the oldest expected block
    always @(posedge clock) begin
        if (!reset && out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
                $display("Output transfer at %0t ns with no job outstanding", $time);
                failures++;
            end else begin
                check_equal("ciphertext", out_data, expected_q.pop_front());
            end
            results++;
        end
    end

    always @(negedge clock) begin
        stall_rng = xorshift(stall_rng);
        out_ready = stall_on ? (stall_rng[2:0] > 3'd2) : 1'b1;   // Roughly 60% ready
        if (jobs_accepted - results > max_in_flight) begin
            max_in_flight = jobs_accepted - results;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        int latency;
        bit seen;
        reset     = 1'b0;
        in_valid  = 1'b0;
        in_beat   = '0;
        out_ready = 1'b1;
        @(negedge clock);
        reset = 1'b1;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_equal("out_valid after reset", out_valid, 1'b0);
        check_equal("in_ready after reset", in_ready, 1'b1);

        // Single job to measure latency from the last accepted beat
        send_job(random_block(), {random_block(), random_block(), random_block()});
        @(negedge clock);
        in_valid = 1'b0;
        latency  = 0;
        seen     = 1'b0;
        while (!seen && latency < drain_timeout) begin
            @(posedge clock);
            latency++;
            seen = out_valid;
        end
        if (seen) begin
            check_equal("latency", latency, rounds + 2);
        end else begin
            $display("Timeout: out_valid never rose after the single job");
            timeouts++;
        end
        wait_for_results("latency");

        for (int j = 0; j < 20; j++) begin
            send_job(random_block(), {random_block(), random_block(), random_block()});
            release_input();
            wait_for_results("single job");
        end

        max_in_flight = 0;
        for (int j = 0; j < 12; j++) begin
            send_job(random_block(), {random_block(), random_block(), random_block()});
        end
        release_input();
        wait_for_results("back to back");
        if (max_in_flight < 2) begin
            $display("Pipeline never held more than one job while jobs were sent back to back");
            failures++;
        end

        gaps_on  = 1'b1;
        stall_on = 1'b1;
        for (int j = 0; j < 24; j++) begin
            send_job(random_block(), {random_block(), random_block(), random_block()});
        end
        release_input();
        wait_for_results("back-pressure");
        stall_on = 1'b0;

        // Any duplicate would show up during this idle stretch
        repeat (rounds + 8) @(negedge clock);
        check_equal("result count", results, jobs_accepted);
        check_equal("jobs left in queue", expected_q.size(), 0);

        $display("Errors: %0d mismatches, %0d other, %0d timeouts, %0d assertion failures",
                 mismatches, failures, timeouts, dut_i.assert_i.failure_count);
        if (mismatches + failures + timeouts + dut_i.assert_i.failure_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
source/skinny_cipher_pkg.sv
source/skinny_link_pkg.sv
source/skinny_loader.sv
source/skinny_round.sv
source/skinny_drain.sv
source/skinny_top.sv
bench/skinny_assert.sv
bench/skinny_tb.sv

// ==== Bender.yml ====
package:
  name: skinny_128_384

sources:
  - include_dirs:
      - include
    files:
      - source/skinny_cipher_pkg.sv
      - source/skinny_link_pkg.sv
      - source/skinny_loader.sv
      - source/skinny_round.sv
      - source/skinny_drain.sv
      - source/skinny_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - bench/skinny_assert.sv
      - bench/skinny_tb.sv
